// ==== src.f ====
logic/mmuPkg.sv
logic/cp0TlbRegs.sv
logic/tlbArray.sv
logic/addrTranslator.sv
logic/mmuTop.sv
bench/mmuTop_sva.sv
bench/mmuTb.sv

// ==== Bender.yml ====
package:
  name: mmu

sources:
  - logic/mmuPkg.sv
  - logic/cp0TlbRegs.sv
  - logic/tlbArray.sv
  - logic/addrTranslator.sv
  - logic/mmuTop.sv
  - target: simulation
    files:
      - bench/mmuTop_sva.sv
      - bench/mmuTb.sv

// ==== bench/mmuTb.sv ====
`timescale 1ns/100ps

module mmuTb;
    import mmuPkg::*;

    // operations per test: reset, unmapped, write, exceptions, asid, readback
    localparam int opsTotal   = 28 + 20 + 120 + 168 + 65 + 144;
    localparam int cycleLimit = opsTotal * 4 + 200;

    logic        clk, arstN;
    logic [31:0] virtIaddr, virtDaddr, cp0Wdata;
    logic        memRead, memWrite, cp0We;
    tlbOpT       tlbOp;
    cp0SelT      cp0Sel;
    logic [31:0] physIaddr, physDaddr, cp0Rdata;
    fetchExcT    fetchExc;
    dataExcT     dataExc;

    // reference copies of the CP0 registers and the entries
    logic [31:0] regIndex, regHi, regLo0, regLo1;
    logic [31:0] mHi  [tlbEntries];  // EntryHi layout
    logic [31:0] mLo0 [tlbEntries];
    logic [31:0] mLo1 [tlbEntries];  // bit 0 unused, g kept in mG
    logic        mG   [tlbEntries];

    logic [31:0] lfsrState = 32'hca92;
    int          errors, checks, testCount, cycleCount, errMark;

    mmuTop DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] lfsrBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] pickVaddr();
        logic [3:0]  i;
        logic [31:0] r;
        if (lfsrBits(1)) begin
            i = 4'(lfsrBits(4));
            r = lfsrBits(13);
            return {mHi[i][31:13], r[12:0]};  // onto a programmed page pair
        end
        return lfsrBits(32);
    endfunction

    function automatic logic [31:0] unmappedVaddr();
        logic [31:0] r;
        r = lfsrBits(30);
        return {2'b10, r[29:0]};  // kseg0 or kseg1
    endfunction

    function automatic logic [31:0] expPhys(input logic [31:0] va, input logic [31:0] lo);
        if (va[31:30] == 2'b10)
            return {3'b000, va[28:0]};  // segment bits stripped
        return {lo[25:6], va[11:0]};
    endfunction

    function automatic void searchModel(input logic [18:0] vpn2, input logic odd,
                                        output logic found, output logic [3:0] idx,
                                        output logic [31:0] lo);
        found = 1'b0;
        idx   = '0;
        lo    = '0;
        for (int i = 0; i < tlbEntries; i++) begin
            if (mHi[i][31:13] == vpn2 && (mG[i] || mHi[i][7:0] == regHi[7:0])) begin
                found = 1'b1;
                idx   = 4'(i);
                lo    = odd ? mLo1[i] : mLo0[i];
            end
        end
    endfunction

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic endTest(input string name, input int errsAtStart);
        testCount++;
        $display("test %s finished with %0d errors", name, errors - errsAtStart);
    endtask

    task automatic dropStrobes();
        cp0We = 1'b0;
        tlbOp = tlbNone;
    endtask

    task automatic cp0Write(input cp0SelT sel, input logic [31:0] data);
        @(negedge clk);
        dropStrobes();
        cp0We    = 1'b1;
        cp0Sel   = sel;
        cp0Wdata = data;
        case (sel)
            selIndex:    regIndex = {regIndex[31], 27'b0, data[3:0]};  // P untouched
            selEntryHi:  regHi    = {data[31:13], 5'b0, data[7:0]};
            selEntryLo0: regLo0   = {6'b0, data[25:0]};
            default:     regLo1   = {6'b0, data[25:0]};
        endcase
    endtask

    task automatic tlbDo(input tlbOpT op);
        logic        hit;
        logic [3:0]  idx, i;
        logic [31:0] lo;
        @(negedge clk);
        dropStrobes();
        memRead  = 1'b0;
        memWrite = 1'b0;
        tlbOp    = op;
        i        = regIndex[3:0];
        if (op == tlbWrite) begin
            mHi[i]  = regHi;
            mG[i]   = regLo0[0] & regLo1[0];
            mLo0[i] = {regLo0[31:1], 1'b0};
            mLo1[i] = {regLo1[31:1], 1'b0};
        end else if (op == tlbRead) begin
            regHi  = mHi[i];
            regLo0 = {mLo0[i][31:1], mG[i]};
            regLo1 = {mLo1[i][31:1], mG[i]};
        end else if (op == tlbProbe) begin
            searchModel(regHi[31:13], 1'b0, hit, idx, lo);
            if (hit)
                regIndex = {28'b0, idx};
            else
                regIndex[31] = 1'b1;
        end
    endtask

    task automatic readCheck(input string name, input cp0SelT sel, input logic [31:0] exp);
        @(negedge clk);
        dropStrobes();
        cp0Sel = sel;
        #10;
        checkVal(name, exp, cp0Rdata);
    endtask

    // vd holds v1, d1, v0, d0 and g holds g1, g0
    task automatic writeEntry(input logic [3:0] idx, input logic [7:0] asid,
                              input logic [1:0] g, input logic [3:0] vd);
        logic [31:0] r;
        r = lfsrBits(28);
        cp0Write(selIndex, {r[27:0], idx});
        r = lfsrBits(18);
        cp0Write(selEntryHi, {1'b0, r[12:0], 1'b1, idx, r[17:13], asid});  // vpn2 unique per slot
        r = lfsrBits(32);
        cp0Write(selEntryLo0, {r[31:3], vd[0], vd[1], g[0]});
        r = lfsrBits(32);
        cp0Write(selEntryLo1, {r[31:3], vd[2], vd[3], g[1]});
        tlbDo(tlbWrite);
    endtask

    task automatic lookup(input string name, input logic [31:0] ia, input logic [31:0] da,
                          input logic rd, input logic wr);
        logic        iHit, dHit, iMap, dMap;
        logic [3:0]  iIdx, dIdx;
        logic [31:0] iLo, dLo;
        fetchExcT    expF;
        dataExcT     expD;
        @(negedge clk);
        dropStrobes();
        virtIaddr = ia;
        virtDaddr = da;
        memRead   = rd;
        memWrite  = wr;
        #10;
        iMap = (ia[31:30] != 2'b10);
        dMap = (da[31:30] != 2'b10);
        searchModel(ia[31:13], ia[12], iHit, iIdx, iLo);
        searchModel(da[31:13], da[12], dHit, dIdx, dLo);
        expF = fexNone;
        if (iMap && !iHit)
            expF = fexRefill;
        else if (iMap && !iLo[1])
            expF = fexInvalid;
        expD = dexNone;
        if (dMap && wr) begin
            if (!dHit)
                expD = dexStoreRefill;
            else if (!dLo[1])
                expD = dexStoreInvalid;
            else if (!dLo[2])
                expD = dexModified;
        end else if (dMap && rd) begin
            if (!dHit)
                expD = dexLoadRefill;
            else if (!dLo[1])
                expD = dexLoadInvalid;
        end
        checkVal({name, " fetchExc"}, expF, fetchExc);
        checkVal({name, " dataExc"}, expD, dataExc);
        if (!iMap || (iHit && iLo[1]))
            checkVal({name, " physIaddr"}, expPhys(ia, iLo), physIaddr);
        if (!dMap || (dHit && dLo[1]))
            checkVal({name, " physDaddr"}, expPhys(da, dLo), physDaddr);
    endtask

    initial begin
        logic [3:0]  idx;
        logic [7:0]  asidA;
        logic [31:0] r;
        errors    = 0;
        checks    = 0;
        testCount = 0;
        arstN     = 1'b0;
        virtIaddr = '0;
        virtDaddr = '0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        tlbOp     = tlbNone;
        cp0We     = 1'b0;
        cp0Sel    = selIndex;
        cp0Wdata  = '0;
        regIndex  = '0;
        regHi     = '0;
        regLo0    = '0;
        regLo1    = '0;
        for (int i = 0; i < tlbEntries; i++) begin
            mHi[i]  = '0;
            mLo0[i] = '0;
            mLo1[i] = '0;
            mG[i]   = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        errMark = errors;
        readCheck("reset Index", selIndex, 32'h0);
        readCheck("reset EntryHi", selEntryHi, 32'h0);
        readCheck("reset EntryLo0", selEntryLo0, 32'h0);
        readCheck("reset EntryLo1", selEntryLo1, 32'h0);
        for (int k = 0; k < 24; k++)
            lookup("reset lookup", pickVaddr(), pickVaddr(), 1'b1, 1'b0);
        endTest("reset state", errMark);

        errMark = errors;
        for (int k = 0; k < 20; k++) begin
            r = lfsrBits(2);
            lookup("unmapped", unmappedVaddr(), unmappedVaddr(), r[0], r[1]);
        end
        endTest("unmapped segments", errMark);

        errMark = errors;
        for (int k = 0; k < 16; k++) begin
            r = lfsrBits(10);
            writeEntry(4'(k), r[7:0], 2'b11, {1'b1, r[8], 1'b1, r[9]});
        end
        for (int k = 0; k < 40; k++)
            lookup("write translate", pickVaddr(), pickVaddr(), 1'b1, 1'b0);
        endTest("write then translate", errMark);

        errMark = errors;
        for (int k = 0; k < 24; k++) begin
            r   = lfsrBits(16);
            idx = r[3:0];
            writeEntry(idx, r[11:4], 2'b11, r[15:12]);
            r = lfsrBits(30);
            lookup("exception hit", {mHi[idx][31:13], r[12:0]}, {mHi[idx][31:13], r[25:13]},
                   r[26], r[27]);
            lookup("exception any", pickVaddr(), pickVaddr(), r[28], r[29]);
        end
        endTest("exception rules", errMark);

        errMark = errors;
        asidA   = 8'(lfsrBits(8));
        for (int k = 0; k < 8; k++) begin
            r = lfsrBits(15);
            writeEntry(r[3:0], r[4] ? asidA : r[12:5], r[13] ? 2'b11 : {r[14], ~r[14]},
                       4'b1111);
        end
        r = lfsrBits(19);
        cp0Write(selEntryHi, {r[18:0], 5'b0, asidA});
        for (int k = 0; k < 24; k++)
            lookup("asid global", pickVaddr(), pickVaddr(), 1'b1, 1'b0);
        endTest("asid and global", errMark);

        errMark = errors;
        for (int k = 0; k < 8; k++) begin
            r   = lfsrBits(14);
            idx = r[3:0];
            writeEntry(idx, r[11:4], r[13:12], 4'(lfsrBits(4)));
            cp0Write(selEntryHi, lfsrBits(32));  // scramble so TLBR has to reload
            cp0Write(selEntryLo0, lfsrBits(32));
            cp0Write(selEntryLo1, lfsrBits(32));
            tlbDo(tlbRead);
            readCheck("readback EntryHi", selEntryHi, regHi);
            readCheck("readback EntryLo0", selEntryLo0, regLo0);
            readCheck("readback EntryLo1", selEntryLo1, regLo1);
            cp0Write(selIndex, lfsrBits(32));  // stale index so TLBP has to reload
            tlbDo(tlbProbe);
            readCheck("probe hit Index", selIndex, regIndex);
            r = lfsrBits(18);
            cp0Write(selEntryHi, {1'b1, r[17:0], 13'(lfsrBits(13))});  // no entry has bit 31 set
            tlbDo(tlbProbe);
            readCheck("probe miss Index", selIndex, regIndex);
        end
        endTest("readback and probe", errMark);

        $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/mmuTop_sva.sv ====
`timescale 1ns/100ps

module mmuTopSva (
    input logic              clk,
    input logic              arstN,
    input mmuPkg::tlbOpT     tlbOp,
    input logic              tlbWe,
    input logic [31:0]       virtIaddr,
    input mmuPkg::fetchExcT  fetchExc,
    input logic              memRead,
    input logic              memWrite,
    input mmuPkg::dataExcT   dataExc
);
    import mmuPkg::*;

    // back to back writes only with a repeated TLBWI
    writeOnce: assert property (@(posedge clk) disable iff (!arstN)
        (tlbWe && $past(tlbWe)) |-> (tlbOp == tlbWrite && $past(tlbOp) == tlbWrite))
        else $error("tlbWe held high without a repeated write opcode");

    unmappedFetch: assert property (@(posedge clk) disable iff (!arstN)
        (virtIaddr >= kseg0Base && virtIaddr < kseg2Base) |-> fetchExc == fexNone)
        else $error("unmapped fetch raised an exception");

    idleData: assert property (@(posedge clk) disable iff (!arstN)
        (!memRead && !memWrite) |-> dataExc == dexNone)
        else $error("idle data port raised an exception");

endmodule

bind mmuTop mmuTopSva uSva (.*);

// ==== logic/mmuTop.sv ====
`timescale 1ns/100ps

module mmuTop (
    input  logic                clk,
    input  logic                arstN,
    input  logic [31:0]         virtIaddr,
    input  logic [31:0]         virtDaddr,
    input  logic                memRead,
    input  logic                memWrite,
    input  mmuPkg::tlbOpT       tlbOp,
    input  logic                cp0We,
    input  mmuPkg::cp0SelT      cp0Sel,
    input  logic [31:0]         cp0Wdata,
    output logic [31:0]         physIaddr,
    output logic [31:0]         physDaddr,
    output mmuPkg::fetchExcT    fetchExc,
    output mmuPkg::dataExcT     dataExc,
    output logic [31:0]         cp0Rdata
);
    import mmuPkg::*;

    logic                 tlbWe, probeSel, wrG, rdG;
    logic [tlbIndexW-1:0] entryIndex, s1Index;
    logic [vpn2W-1:0]     hiVpn2, rdVpn2;
    logic [asidW-1:0]     hiAsid, rdAsid;
    logic [pfnW-1:0]      wrPfn0, wrPfn1, rdPfn0, rdPfn1, s0Pfn, s1Pfn;
    logic [2:0]           wrC0, wrC1, rdC0, rdC1;
    logic                 wrD0, wrV0, wrD1, wrV1;
    logic                 rdD0, rdV0, rdD1, rdV1;
    logic                 s0Found, s0V, s1Found, s1D, s1V;

    cp0TlbRegs uCp0 (
        .probeFound (s1Found),
        .probeIndex (s1Index),
        .*
    );

    tlbArray uTlb (
        .s0Vpn2     (virtIaddr[31:13]),
        .s0Odd      (virtIaddr[12]),
        .s0D        (),                  // fetch ignores dirty
        .s1Vpn2     (virtDaddr[31:13]),
        .s1Odd      (virtDaddr[12]),
        .probeVpn2  (hiVpn2),
        .asid       (hiAsid),
        .we         (tlbWe),
        .index      (entryIndex),
        .wrVpn2     (hiVpn2),
        .wrAsid     (hiAsid),
        .*
    );

    addrTranslator uXlat (.*);

endmodule

// ==== logic/addrTranslator.sv ====
`timescale 1ns/100ps

module addrTranslator (
    input  logic [31:0]             virtIaddr,
    input  logic [31:0]             virtDaddr,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic                    s0Found,
    input  logic [mmuPkg::pfnW-1:0] s0Pfn,
    input  logic                    s0V,
    input  logic                    s1Found,
    input  logic [mmuPkg::pfnW-1:0] s1Pfn,
    input  logic                    s1D,
    input  logic                    s1V,
    output logic [31:0]             physIaddr,
    output logic [31:0]             physDaddr,
    output mmuPkg::fetchExcT        fetchExc,
    output mmuPkg::dataExcT         dataExc
);
    import mmuPkg::*;

    logic iMapped;
    logic dMapped;

    // kuseg and kseg2/3 go through the TLB
    function automatic logic isMapped(input logic [31:0] va);
        return (va < kseg0Base) || (va >= kseg2Base);
    endfunction

    function automatic logic [31:0] toPhys(input logic [31:0] va, input logic [pfnW-1:0] pfn);
        if (va >= kseg1Base && va < kseg2Base)
            return va - kseg1Base;
        else if (va >= kseg0Base && va < kseg1Base)
            return va - kseg0Base;
        else
            return {pfn, va[11:0]};
    endfunction

    assign iMapped   = isMapped(virtIaddr);
    assign dMapped   = isMapped(virtDaddr);
    assign physIaddr = toPhys(virtIaddr, s0Pfn);
    assign physDaddr = toPhys(virtDaddr, s1Pfn);

    always_comb begin
        fetchExc = fexNone;
        if (iMapped) begin
            if (!s0Found)
                fetchExc = fexRefill;
            else if (!s0V)
                fetchExc = fexInvalid;
        end
    end

    // store wins when both strobes are up
    always_comb begin
        dataExc = dexNone;
        if (dMapped && memWrite) begin
            if (!s1Found)
                dataExc = dexStoreRefill;
            else if (!s1V)
                dataExc = dexStoreInvalid;
            else if (!s1D)
                dataExc = dexModified;  // clean page
        end else if (dMapped && memRead) begin
            if (!s1Found)
                dataExc = dexLoadRefill;
            else if (!s1V)
                dataExc = dexLoadInvalid;
        end
    end

endmodule

// ==== logic/tlbArray.sv ====
`timescale 1ns/100ps

module tlbArray (
    input  logic                         clk,
    input  logic                         arstN,
    // search port 0, fetch
    input  logic [mmuPkg::vpn2W-1:0]     s0Vpn2,
    input  logic                         s0Odd,
    output logic                         s0Found,
    output logic [mmuPkg::pfnW-1:0]      s0Pfn,
    output logic                         s0D, s0V,
    // search port 1, data or probe
    input  logic [mmuPkg::vpn2W-1:0]     s1Vpn2,
    input  logic                         s1Odd,
    input  logic                         probeSel,
    input  logic [mmuPkg::vpn2W-1:0]     probeVpn2,
    input  logic [mmuPkg::asidW-1:0]     asid,
    output logic                         s1Found,
    output logic [mmuPkg::tlbIndexW-1:0] s1Index,
    output logic [mmuPkg::pfnW-1:0]      s1Pfn,
    output logic                         s1D, s1V,
    // write port
    input  logic                         we,
    input  logic [mmuPkg::tlbIndexW-1:0] index,
    input  logic [mmuPkg::vpn2W-1:0]     wrVpn2,
    input  logic [mmuPkg::asidW-1:0]     wrAsid,
    input  logic                         wrG,
    input  logic [mmuPkg::pfnW-1:0]      wrPfn0, wrPfn1,
    input  logic [2:0]                   wrC0, wrC1,
    input  logic                         wrD0, wrV0, wrD1, wrV1,
    // read port, shares index
    output logic [mmuPkg::vpn2W-1:0]     rdVpn2,
    output logic [mmuPkg::asidW-1:0]     rdAsid,
    output logic                         rdG,
    output logic [mmuPkg::pfnW-1:0]      rdPfn0, rdPfn1,
    output logic [2:0]                   rdC0, rdC1,
    output logic                         rdD0, rdV0, rdD1, rdV1
);
    import mmuPkg::*;

    logic [vpn2W-1:0] vpn2Mem [tlbEntries];
    logic [asidW-1:0] asidMem [tlbEntries];
    logic             gMem    [tlbEntries];
    logic             v0Mem   [tlbEntries];
    logic             v1Mem   [tlbEntries];
    logic [pfnW-1:0]  pfn0Mem [tlbEntries];
    logic [pfnW-1:0]  pfn1Mem [tlbEntries];
    logic [2:0]       c0Mem   [tlbEntries];
    logic [2:0]       c1Mem   [tlbEntries];
    logic             d0Mem   [tlbEntries];
    logic             d1Mem   [tlbEntries];

    logic [vpn2W-1:0]      s1Key;
    logic [tlbEntries-1:0] hit0, hit1;
    logic [tlbIndexW-1:0]  s0Idx;

    assign s1Key = probeSel ? probeVpn2 : s1Vpn2;  // TLBP borrows the data port

    // tag and valid bits
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < tlbEntries; i++) begin
                vpn2Mem[i] <= '0;
                asidMem[i] <= '0;
                gMem[i]    <= 1'b0;
                v0Mem[i]   <= 1'b0;
                v1Mem[i]   <= 1'b0;
            end
        end else if (we) begin
            vpn2Mem[index] <= wrVpn2;
            asidMem[index] <= wrAsid;
            gMem[index]    <= wrG;
            v0Mem[index]   <= wrV0;
            v1Mem[index]   <= wrV1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            pfn0Mem[index] <= wrPfn0;
            pfn1Mem[index] <= wrPfn1;
            c0Mem[index]   <= wrC0;
            c1Mem[index]   <= wrC1;
            d0Mem[index]   <= wrD0;
            d1Mem[index]   <= wrD1;
        end
    end

    // fully associative compare on both ports
    always_comb begin
        for (int i = 0; i < tlbEntries; i++) begin
            hit0[i] = (vpn2Mem[i] == s0Vpn2) && (gMem[i] || asidMem[i] == asid);
            hit1[i] = (vpn2Mem[i] == s1Key) && (gMem[i] || asidMem[i] == asid);
        end
    end

    always_comb begin
        s0Idx   = '0;
        s1Index = '0;
        for (int i = 0; i < tlbEntries; i++) begin
            if (hit0[i])
                s0Idx = tlbIndexW'(i);
            if (hit1[i])
                s1Index = tlbIndexW'(i);
        end
    end

    assign s0Found = |hit0;
    assign s0Pfn   = s0Odd ? pfn1Mem[s0Idx] : pfn0Mem[s0Idx];
    assign s0D     = s0Odd ? d1Mem[s0Idx] : d0Mem[s0Idx];
    assign s0V     = s0Odd ? v1Mem[s0Idx] : v0Mem[s0Idx];

    assign s1Found = |hit1;
    assign s1Pfn   = s1Odd ? pfn1Mem[s1Index] : pfn0Mem[s1Index];
    assign s1D     = s1Odd ? d1Mem[s1Index] : d0Mem[s1Index];
    assign s1V     = s1Odd ? v1Mem[s1Index] : v0Mem[s1Index];

    assign rdVpn2 = vpn2Mem[index];
    assign rdAsid = asidMem[index];
    assign rdG    = gMem[index];
    assign rdPfn0 = pfn0Mem[index];
    assign rdPfn1 = pfn1Mem[index];
    assign rdC0   = c0Mem[index];
    assign rdC1   = c1Mem[index];
    assign rdD0   = d0Mem[index];
    assign rdV0   = v0Mem[index];
    assign rdD1   = d1Mem[index];
    assign rdV1   = v1Mem[index];

endmodule

// ==== logic/cp0TlbRegs.sv ====
`timescale 1ns/100ps

module cp0TlbRegs (
    input  logic                         clk,
    input  logic                         arstN,
    input  mmuPkg::tlbOpT                tlbOp,
    input  logic                         cp0We,
    input  mmuPkg::cp0SelT               cp0Sel,
    input  logic [31:0]                  cp0Wdata,
    input  logic [mmuPkg::vpn2W-1:0]     rdVpn2,
    input  logic [mmuPkg::asidW-1:0]     rdAsid,
    input  logic                         rdG,
    input  logic [mmuPkg::pfnW-1:0]      rdPfn0,
    input  logic [mmuPkg::pfnW-1:0]      rdPfn1,
    input  logic [2:0]                   rdC0,
    input  logic [2:0]                   rdC1,
    input  logic                         rdD0, rdV0, rdD1, rdV1,
    input  logic                         probeFound,
    input  logic [mmuPkg::tlbIndexW-1:0] probeIndex,
    output logic [31:0]                  cp0Rdata,
    output logic                         tlbWe,
    output logic                         probeSel,
    output logic [mmuPkg::tlbIndexW-1:0] entryIndex,
    output logic [mmuPkg::vpn2W-1:0]     hiVpn2,
    output logic [mmuPkg::asidW-1:0]     hiAsid,
    output logic                         wrG,
    output logic [mmuPkg::pfnW-1:0]      wrPfn0,
    output logic [mmuPkg::pfnW-1:0]      wrPfn1,
    output logic [2:0]                   wrC0,
    output logic [2:0]                   wrC1,
    output logic                         wrD0, wrV0, wrD1, wrV1
);
    import mmuPkg::*;

    logic                 probeFail;  // Index.P
    logic [tlbIndexW-1:0] idxField;
    logic [pfnW-1:0]      lo0Pfn, lo1Pfn;
    logic [2:0]           lo0C, lo1C;
    logic                 lo0D, lo0V, lo0G;
    logic                 lo1D, lo1V, lo1G;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            probeFail <= 1'b0;
            idxField  <= '0;
            hiVpn2    <= '0;
            hiAsid    <= '0;
            lo0Pfn    <= '0;
            lo0C      <= '0;
            lo0D      <= 1'b0;
            lo0V      <= 1'b0;
            lo0G      <= 1'b0;
            lo1Pfn    <= '0;
            lo1C      <= '0;
            lo1D      <= 1'b0;
            lo1V      <= 1'b0;
            lo1G      <= 1'b0;
        end else begin
            case (tlbOp)
                tlbRead: begin
                    hiVpn2 <= rdVpn2;
                    hiAsid <= rdAsid;
                    lo0Pfn <= rdPfn0;
                    lo0C   <= rdC0;
                    lo0D   <= rdD0;
                    lo0V   <= rdV0;
                    lo0G   <= rdG;  // one stored g feeds both halves
                    lo1Pfn <= rdPfn1;
                    lo1C   <= rdC1;
                    lo1D   <= rdD1;
                    lo1V   <= rdV1;
                    lo1G   <= rdG;
                end
                tlbProbe: begin
                    probeFail <= ~probeFound;
                    if (probeFound) begin
                        idxField <= probeIndex;
                    end
                end
                default: begin
                    if (cp0We) begin
                        case (cp0Sel)
                            selIndex:   idxField <= cp0Wdata[tlbIndexW-1:0]; // P is read only
                            selEntryHi: begin
                                hiVpn2 <= cp0Wdata[31:13];
                                hiAsid <= cp0Wdata[7:0];
                            end
                            selEntryLo0: begin
                                lo0Pfn <= cp0Wdata[25:6];
                                lo0C   <= cp0Wdata[5:3];
                                lo0D   <= cp0Wdata[2];
                                lo0V   <= cp0Wdata[1];
                                lo0G   <= cp0Wdata[0];
                            end
                            default: begin
                                lo1Pfn <= cp0Wdata[25:6];
                                lo1C   <= cp0Wdata[5:3];
                                lo1D   <= cp0Wdata[2];
                                lo1V   <= cp0Wdata[1];
                                lo1G   <= cp0Wdata[0];
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (cp0Sel)
            selIndex:    cp0Rdata = {probeFail, {(31 - tlbIndexW){1'b0}}, idxField};
            selEntryHi:  cp0Rdata = {hiVpn2, 5'b0, hiAsid};
            selEntryLo0: cp0Rdata = {6'b0, lo0Pfn, lo0C, lo0D, lo0V, lo0G};
            default:     cp0Rdata = {6'b0, lo1Pfn, lo1C, lo1D, lo1V, lo1G};
        endcase
    end

    assign tlbWe      = (tlbOp == tlbWrite);
    assign probeSel   = (tlbOp == tlbProbe);
    assign entryIndex = idxField;

    assign wrG    = lo0G & lo1G;  // entry is global only if both halves say so
    assign wrPfn0 = lo0Pfn;
    assign wrC0   = lo0C;
    assign wrD0   = lo0D;
    assign wrV0   = lo0V;
    assign wrPfn1 = lo1Pfn;
    assign wrC1   = lo1C;
    assign wrD1   = lo1D;
    assign wrV1   = lo1V;

endmodule

// ==== logic/mmuPkg.sv ====
package mmuPkg;

    // TLB geometry
    localparam int unsigned tlbEntries = 16;
    localparam int unsigned tlbIndexW  = 4;
    localparam int unsigned vpn2W      = 19;
    localparam int unsigned pfnW       = 20;
    localparam int unsigned asidW      = 8;

    // segment bounds, kseg0 and kseg1 bypass the TLB
    localparam logic [31:0] kseg0Base = 32'h8000_0000;
    localparam logic [31:0] kseg1Base = 32'hA000_0000;
    localparam logic [31:0] kseg2Base = 32'hC000_0000;

    typedef enum logic [1:0] {
        tlbNone  = 2'd0,
        tlbWrite = 2'd1,  // TLBWI
        tlbRead  = 2'd2,  // TLBR
        tlbProbe = 2'd3   // TLBP
    } tlbOpT;

    typedef enum logic [1:0] {
        selIndex    = 2'd0,
        selEntryHi  = 2'd1,
        selEntryLo0 = 2'd2,
        selEntryLo1 = 2'd3
    } cp0SelT;

    typedef enum logic [1:0] {
        fexNone    = 2'd0,
        fexRefill  = 2'd1,
        fexInvalid = 2'd2
    } fetchExcT;

    typedef enum logic [2:0] {
        dexNone         = 3'd0,
        dexLoadRefill   = 3'd1,
        dexLoadInvalid  = 3'd2,
        dexStoreRefill  = 3'd3,
        dexStoreInvalid = 3'd4,
        dexModified     = 3'd5
    } dataExcT;

endpackage
